/* hw/aux_defines.svh */
`default_nettype none

`ifndef AUX_DEFINES_SVH
`define AUX_DEFINES_SVH

// byte and native address widths
`define AUX_BYTE_W 8
`define AUX_ADDR_W 20

// idle cycles allowed after a message before the reply times out
`define AUX_REPLY_TIMEOUT 32

// retransmissions after the first try
`define AUX_MAX_RETRIES 3

`endif

`default_nettype wire

/* hw/aux_pkg.sv */
`include "aux_defines.svh"
`default_nettype none

package aux_pkg;

    typedef logic [`AUX_BYTE_W-1:0] aux_byte_t;
    typedef logic [`AUX_ADDR_W-1:0] aux_addr_t;

    // request opcode from spm / lpm
    typedef enum logic [1:0] {
        NATIVE_WRITE = 2'b00,
        NATIVE_READ  = 2'b01
    } aux_cmd_e;

    // reply code, bits 5:4 of the first reply byte
    typedef enum logic [1:0] {
        REPLY_ACK   = 2'b00,
        REPLY_NACK  = 2'b01,
        REPLY_DEFER = 2'b10
    } aux_reply_e;

    typedef enum logic {
        SRC_SPM = 1'b0,
        SRC_LPM = 1'b1
    } req_src_e;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_REPLY
    } ctrl_state_e;

    typedef enum logic [2:0] {
        ENC_IDLE,
        ENC_HDR0,
        ENC_HDR1,
        ENC_HDR2,
        ENC_LEN,
        ENC_DATA
    } enc_state_e;

endpackage

`default_nettype wire

/* hw/aux_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one native request, control unit -> encoder
interface aux_req_if import aux_pkg::*; ();

    logic      vld;
    aux_cmd_e  cmd;
    aux_addr_t address;
    aux_byte_t len;
    aux_byte_t data;

    modport ctrl (
        output vld,
        output cmd,
        output address,
        output len,
        output data
    );

    modport enc (
        input vld,
        input cmd,
        input address,
        input len,
        input data
    );

endinterface

`default_nettype wire

/* hw/aux_ctrl_unit.sv */
`timescale 1ns/1ps
`include "aux_defines.svh"
`default_nettype none

module aux_ctrl_unit import aux_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spm_vld,
    input  aux_cmd_e   spm_cmd,
    input  aux_addr_t  spm_address,
    input  aux_byte_t  spm_len,
    input  aux_byte_t  spm_data,
    input  logic       lpm_vld,
    input  aux_cmd_e   lpm_cmd,
    input  aux_addr_t  lpm_address,
    input  aux_byte_t  lpm_len,
    input  aux_byte_t  lpm_data,
    input  aux_reply_e reply_ack,
    input  logic       reply_ack_vld,
    input  logic       phy_start_stop,
    input  logic       timer_timeout,
    aux_req_if.ctrl    req,
    output logic       busy,
    output req_src_e   reply_src,
    output logic       native_failed
);

    localparam int RETRY_W = $clog2(`AUX_MAX_RETRIES + 1);

    ctrl_state_e        state;
    logic [RETRY_W-1:0] retry_cnt;
    logic               reply_done;
    logic               new_req;
    logic               retry_req;
    logic               end_req;
    logic               can_retry;

    aux_cmd_e           held_cmd;
    aux_addr_t          held_address;
    aux_byte_t          held_len;
    aux_byte_t          held_data;

    ////////////////////////////////////////
    // arbitration and retry decisions
    ////////////////////////////////////////

    assign new_req   = spm_vld || lpm_vld;
    assign retry_req = (reply_ack_vld && reply_ack == REPLY_DEFER) || timer_timeout;
    // ack or nack closes the transaction
    assign end_req   = reply_done || (reply_ack_vld && reply_ack != REPLY_DEFER);
    assign can_retry = retry_cnt < RETRY_W'(`AUX_MAX_RETRIES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= IDLE;
            retry_cnt     <= '0;
            reply_done    <= 1'b0;
            native_failed <= 1'b0;
            reply_src     <= SRC_SPM;
        end else begin
            native_failed <= 1'b0;
            case (state)
                IDLE: begin
                    if (new_req) begin
                        state      <= ISSUE;
                        retry_cnt  <= '0;
                        reply_done <= 1'b0;
                        // spm has priority
                        reply_src  <= spm_vld ? SRC_SPM : SRC_LPM;
                    end
                end
                ISSUE: begin
                    state <= WAIT_REPLY;
                end
                WAIT_REPLY: begin
                    if (native_failed) begin
                        state <= IDLE;
                    end else if (end_req) begin
                        reply_done <= 1'b1;
                        // hold busy until the reply burst is over
                        if (!phy_start_stop) begin
                            state <= IDLE;
                        end
                    end else if (retry_req) begin
                        if (can_retry) begin
                            retry_cnt <= retry_cnt + 1'b1;
                            state     <= ISSUE;
                        end else begin
                            native_failed <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // winner is held for retransmission
    always_ff @(posedge clk) begin
        if (state == IDLE && new_req) begin
            held_cmd     <= spm_vld ? spm_cmd     : lpm_cmd;
            held_address <= spm_vld ? spm_address : lpm_address;
            held_len     <= spm_vld ? spm_len     : lpm_len;
            held_data    <= spm_vld ? spm_data    : lpm_data;
        end
    end

    assign req.vld     = (state == ISSUE);
    assign req.cmd     = held_cmd;
    assign req.address = held_address;
    assign req.len     = held_len;
    assign req.data    = held_data;

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

/* hw/native_msg_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module native_msg_encoder import aux_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    aux_req_if.enc    req,
    output aux_byte_t tx_byte,
    output logic      tx_vld
);

    enc_state_e state;
    aux_cmd_e   cmd_q;
    aux_addr_t  address_q;
    aux_byte_t  len_q;
    aux_byte_t  data_q;
    logic [3:0] cmd_nibble;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ENC_IDLE;
        end else begin
            case (state)
                ENC_IDLE: begin
                    if (req.vld) begin
                        state <= ENC_HDR0;
                    end
                end
                ENC_HDR0: state <= ENC_HDR1;
                ENC_HDR1: state <= ENC_HDR2;
                ENC_HDR2: state <= ENC_LEN;
                // data byte only follows on writes
                ENC_LEN:  state <= (cmd_q == NATIVE_WRITE) ? ENC_DATA : ENC_IDLE;
                default:  state <= ENC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ENC_IDLE && req.vld) begin
            cmd_q     <= req.cmd;
            address_q <= req.address;
            len_q     <= req.len;
            data_q    <= req.data;
        end
    end

    // 1000 write, 1001 read
    assign cmd_nibble = (cmd_q == NATIVE_READ) ? 4'b1001 : 4'b1000;

    always_comb begin
        case (state)
            ENC_HDR0: tx_byte = {cmd_nibble, address_q[19:16]};
            ENC_HDR1: tx_byte = address_q[15:8];
            ENC_HDR2: tx_byte = address_q[7:0];
            ENC_LEN:  tx_byte = len_q;
            ENC_DATA: tx_byte = data_q;
            default:  tx_byte = '0;
        endcase
    end

    assign tx_vld = (state != ENC_IDLE);

endmodule

`default_nettype wire

/* hw/aux_phy_link.sv */
`timescale 1ns/1ps
`include "aux_defines.svh"
`default_nettype none

module aux_phy_link import aux_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  aux_byte_t tx_byte,
    input  logic      tx_vld,
    output aux_byte_t aux_tx_data,
    output logic      aux_start_stop,
    input  aux_byte_t aux_rx_data,
    input  logic      phy_start_stop,
    output aux_byte_t rx_byte,
    output logic      rx_vld,
    output logic      rx_first,
    output logic      timer_timeout
);

    localparam int TMR_W = $clog2(`AUX_REPLY_TIMEOUT);

    logic             phy_q;
    logic             tmr_run;
    logic [TMR_W-1:0] tmr_cnt;

    ////////////////////////////////////////
    // transmit framing
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aux_start_stop <= 1'b0;
            phy_q          <= 1'b0;
        end else begin
            aux_start_stop <= tx_vld;
            phy_q          <= phy_start_stop;
        end
    end

    // data lines up with aux_start_stop
    always_ff @(posedge clk) begin
        aux_tx_data <= tx_byte;
    end

    ////////////////////////////////////////
    // reply capture
    ////////////////////////////////////////

    assign rx_byte  = aux_rx_data;
    assign rx_vld   = phy_start_stop;
    // rising edge of the sink frame
    assign rx_first = phy_start_stop && !phy_q;

    // reply timeout, armed as the message ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmr_run       <= 1'b0;
            tmr_cnt       <= '0;
            timer_timeout <= 1'b0;
        end else begin
            timer_timeout <= 1'b0;
            if (aux_start_stop && !tx_vld) begin
                tmr_run <= 1'b1;
                tmr_cnt <= '0;
            end else if (phy_start_stop) begin
                tmr_run <= 1'b0;
            end else if (tmr_run) begin
                if (tmr_cnt == TMR_W'(`AUX_REPLY_TIMEOUT - 1)) begin
                    tmr_run       <= 1'b0;
                    timer_timeout <= 1'b1;
                end else begin
                    tmr_cnt <= tmr_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/reply_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module reply_decoder import aux_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  aux_byte_t  rx_byte,
    input  logic       rx_vld,
    input  logic       rx_first,
    output aux_reply_e reply_ack,
    output logic       reply_ack_vld,
    output aux_byte_t  reply_data,
    output logic       reply_data_vld
);

    aux_reply_e ack_code;

    // reply code sits in bits 5:4 of the first byte
    always_comb begin
        case (rx_byte[5:4])
            2'b00:   ack_code = REPLY_ACK;
            2'b10:   ack_code = REPLY_DEFER;
            // reserved code handled as nack, no retry
            default: ack_code = REPLY_NACK;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reply_ack_vld  <= 1'b0;
            reply_data_vld <= 1'b0;
        end else begin
            reply_ack_vld  <= rx_vld && rx_first;
            reply_data_vld <= rx_vld && !rx_first;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_vld && rx_first) begin
            reply_ack <= ack_code;
        end
        if (rx_vld && !rx_first) begin
            reply_data <= rx_byte;
        end
    end

endmodule

`default_nettype wire

/* hw/aux_native_top.sv */
`timescale 1ns/1ps
`default_nettype none

module aux_native_top import aux_pkg::*; (
    input  logic       clk_aux,
    input  logic       rst_n,
    input  logic       spm_vld,
    input  aux_cmd_e   spm_cmd,
    input  aux_addr_t  spm_address,
    input  aux_byte_t  spm_len,
    input  aux_byte_t  spm_data,
    input  logic       lpm_vld,
    input  aux_cmd_e   lpm_cmd,
    input  aux_addr_t  lpm_address,
    input  aux_byte_t  lpm_len,
    input  aux_byte_t  lpm_data,
    output aux_byte_t  aux_tx_data,
    output logic       aux_start_stop,
    input  aux_byte_t  aux_rx_data,
    input  logic       phy_start_stop,
    output aux_byte_t  reply_data,
    output logic       reply_data_vld,
    output aux_reply_e reply_ack,
    output logic       reply_ack_vld,
    output req_src_e   reply_src,
    output logic       busy,
    output logic       timer_timeout,
    output logic       native_failed
);

    ////////////////////////////////////////
    // pipeline wires
    ////////////////////////////////////////

    aux_req_if req_bus ();

    aux_byte_t tx_byte;
    logic      tx_vld;
    aux_byte_t rx_byte;
    logic      rx_vld;
    logic      rx_first;

    aux_ctrl_unit u_ctrl (
        .clk            (clk_aux),
        .rst_n          (rst_n),
        .spm_vld        (spm_vld),
        .spm_cmd        (spm_cmd),
        .spm_address    (spm_address),
        .spm_len        (spm_len),
        .spm_data       (spm_data),
        .lpm_vld        (lpm_vld),
        .lpm_cmd        (lpm_cmd),
        .lpm_address    (lpm_address),
        .lpm_len        (lpm_len),
        .lpm_data       (lpm_data),
        .reply_ack      (reply_ack),
        .reply_ack_vld  (reply_ack_vld),
        .phy_start_stop (phy_start_stop),
        .timer_timeout  (timer_timeout),
        .req            (req_bus.ctrl),
        .busy           (busy),
        .reply_src      (reply_src),
        .native_failed  (native_failed)
    );

    native_msg_encoder u_enc (
        .clk     (clk_aux),
        .rst_n   (rst_n),
        .req     (req_bus.enc),
        .tx_byte (tx_byte),
        .tx_vld  (tx_vld)
    );

    aux_phy_link u_phy (
        .clk            (clk_aux),
        .rst_n          (rst_n),
        .tx_byte        (tx_byte),
        .tx_vld         (tx_vld),
        .aux_tx_data    (aux_tx_data),
        .aux_start_stop (aux_start_stop),
        .aux_rx_data    (aux_rx_data),
        .phy_start_stop (phy_start_stop),
        .rx_byte        (rx_byte),
        .rx_vld         (rx_vld),
        .rx_first       (rx_first),
        .timer_timeout  (timer_timeout)
    );

    reply_decoder u_dec (
        .clk            (clk_aux),
        .rst_n          (rst_n),
        .rx_byte        (rx_byte),
        .rx_vld         (rx_vld),
        .rx_first       (rx_first),
        .reply_ack      (reply_ack),
        .reply_ack_vld  (reply_ack_vld),
        .reply_data     (reply_data),
        .reply_data_vld (reply_data_vld)
    );

endmodule

`default_nettype wire

/* tests/aux_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module aux_clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 8;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD;
            clk = ~clk;
        end
    end

    // reset released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/aux_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module aux_asserts (
    input logic clk_aux,
    input logic rst_n,
    input logic aux_start_stop,
    input logic phy_start_stop,
    input logic busy,
    input logic reply_ack_vld,
    input logic timer_timeout,
    input logic native_failed
);

    // running count of violations
    int viol_cnt = 0;

    // half-duplex link
    no_overlap: assert property (@(posedge clk_aux) disable iff (!rst_n)
        !(aux_start_stop && phy_start_stop))
        else begin
            viol_cnt++;
            $error("aux_start_stop and phy_start_stop high in the same cycle");
        end

    tx_while_busy: assert property (@(posedge clk_aux) disable iff (!rst_n)
        aux_start_stop |-> busy)
        else begin
            viol_cnt++;
            $error("aux_start_stop high while busy is low");
        end

    ack_or_timeout: assert property (@(posedge clk_aux) disable iff (!rst_n)
        !(reply_ack_vld && timer_timeout))
        else begin
            viol_cnt++;
            $error("reply_ack_vld and timer_timeout high in the same cycle");
        end

    fail_while_busy: assert property (@(posedge clk_aux) disable iff (!rst_n)
        native_failed |-> busy)
        else begin
            viol_cnt++;
            $error("native_failed pulsed while busy is low");
        end

endmodule

bind aux_native_top aux_asserts u_asserts (
    .clk_aux        (clk_aux),
    .rst_n          (rst_n),
    .aux_start_stop (aux_start_stop),
    .phy_start_stop (phy_start_stop),
    .busy           (busy),
    .reply_ack_vld  (reply_ack_vld),
    .timer_timeout  (timer_timeout),
    .native_failed  (native_failed)
);

`default_nettype wire

/* tests/aux_tb.sv */
`timescale 1ns/1ps
`include "aux_defines.svh"
`default_nettype none

module aux_tb import aux_pkg::*; ();

    localparam int NUM_TESTS  = 7;
    localparam int MAX_CYCLES = NUM_TESTS * 200 + 50;

    // src_mask bit 0 drives spm, bit 1 drives lpm
    typedef struct packed {
        logic [1:0] src_mask;
        aux_cmd_e   cmd;
        aux_addr_t  address;
        aux_byte_t  len;
        aux_byte_t  data;
        logic [2:0] defers;
        logic [2:0] silents;
        logic       nack;
        logic       expect_fail;
    } test_t;

    logic       clk_aux;
    logic       rst_n;
    logic       spm_vld;
    aux_cmd_e   spm_cmd;
    aux_addr_t  spm_address;
    aux_byte_t  spm_len;
    aux_byte_t  spm_data;
    logic       lpm_vld;
    aux_cmd_e   lpm_cmd;
    aux_addr_t  lpm_address;
    aux_byte_t  lpm_len;
    aux_byte_t  lpm_data;
    aux_byte_t  aux_tx_data;
    logic       aux_start_stop;
    aux_byte_t  aux_rx_data;
    logic       phy_start_stop;
    aux_byte_t  reply_data;
    logic       reply_data_vld;
    aux_reply_e reply_ack;
    logic       reply_ack_vld;
    req_src_e   reply_src;
    logic       busy;
    logic       timer_timeout;
    logic       native_failed;

    test_t      test_tab [NUM_TESTS];
    string      name_tab [NUM_TESTS];
    string      cur_name;

    aux_byte_t  exp_msg[$];
    aux_byte_t  cur_msg[$];
    aux_byte_t  sent_data[$];
    aux_byte_t  rcv_data[$];

    // sink behavior for the running test
    int         sink_silents;
    int         sink_defers;
    logic       sink_nack;
    logic       sink_read;
    aux_byte_t  sink_len;

    int         msg_count;
    int         answered;
    int         ack_count;
    int         tmo_count;
    int         fail_count;
    aux_reply_e last_ack;
    int         err_count;
    int         cycle_cnt;

    aux_clk_gen u_clk (
        .clk   (clk_aux),
        .rst_n (rst_n)
    );

    aux_native_top DUT (.*);

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_byte(string what, aux_byte_t exp, aux_byte_t act);
        if (act !== exp) begin
            err_count++;
            $display("ERROR %s: %s expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic check_reply(string what, aux_reply_e exp, aux_reply_e act);
        if (act !== exp) begin
            err_count++;
            $display("ERROR %s: %s expected %s actual %s", cur_name, what, exp.name(),
                     act.name());
        end
    endtask

    task automatic check_src(string what, req_src_e exp, req_src_e act);
        if (act !== exp) begin
            err_count++;
            $display("ERROR %s: %s expected %s actual %s", cur_name, what, exp.name(),
                     act.name());
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (act != exp) begin
            err_count++;
            $display("ERROR %s: %s expected %0d actual %0d", cur_name, what, exp, act);
        end
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    task automatic load_table();
        name_tab[0] = "spm_write";
        test_tab[0] = '{2'b01, NATIVE_WRITE, 20'h00102, 8'h00, 8'h5a, 3'd0, 3'd0, 1'b0, 1'b0};
        name_tab[1] = "lpm_read";
        test_tab[1] = '{2'b10, NATIVE_READ, 20'h00200, 8'h03, 8'h00, 3'd0, 3'd0, 1'b0, 1'b0};
        name_tab[2] = "both_strobe";
        test_tab[2] = '{2'b11, NATIVE_WRITE, 20'h00600, 8'h00, 8'h3c, 3'd0, 3'd0, 1'b0, 1'b0};
        name_tab[3] = "defer_twice";
        test_tab[3] = '{2'b01, NATIVE_READ, 20'h80010, 8'h01, 8'h00, 3'd2, 3'd0, 1'b0, 1'b0};
        name_tab[4] = "silent_sink";
        test_tab[4] = '{2'b10, NATIVE_WRITE, 20'hf0001, 8'h00, 8'ha5, 3'd0, 3'd4, 1'b0, 1'b1};
        name_tab[5] = "nack_reply";
        test_tab[5] = '{2'b01, NATIVE_WRITE, 20'h00050, 8'h00, 8'h11, 3'd0, 3'd0, 1'b1, 1'b0};
        name_tab[6] = "timeout_then_read";
        test_tab[6] = '{2'b10, NATIVE_READ, 20'h4a0c3, 8'h0f, 8'h00, 3'd0, 3'd1, 1'b0, 1'b0};
    endtask

    // expected bytes follow the native header layout
    task automatic prepare_test(test_t t);
        logic [3:0] nibble;
        @(posedge clk_aux);
        #1;
        exp_msg.delete();
        sent_data.delete();
        rcv_data.delete();
        msg_count  = 0;
        answered   = 0;
        ack_count  = 0;
        tmo_count  = 0;
        fail_count = 0;
        nibble = (t.cmd == NATIVE_READ) ? 4'b1001 : 4'b1000;
        exp_msg.push_back({nibble, t.address[19:16]});
        exp_msg.push_back(t.address[15:8]);
        exp_msg.push_back(t.address[7:0]);
        exp_msg.push_back(t.len);
        if (t.cmd == NATIVE_WRITE) begin
            exp_msg.push_back(t.data);
        end
        sink_silents = t.silents;
        sink_defers  = t.defers;
        sink_nack    = t.nack;
        sink_read    = (t.cmd == NATIVE_READ);
        sink_len     = t.len;
    endtask

    task automatic issue_request(test_t t);
        @(posedge clk_aux);
        #1;
        if (t.src_mask[0]) begin
            spm_vld     = 1'b1;
            spm_cmd     = t.cmd;
            spm_address = t.address;
            spm_len     = t.len;
            spm_data    = t.data;
        end
        if (t.src_mask[1]) begin
            lpm_vld = 1'b1;
            if (t.src_mask[0]) begin
                // competing request, loses to spm
                lpm_cmd     = NATIVE_READ;
                lpm_address = ~t.address;
                lpm_len     = 8'h01;
                lpm_data    = ~t.data;
            end else begin
                lpm_cmd     = t.cmd;
                lpm_address = t.address;
                lpm_len     = t.len;
                lpm_data    = t.data;
            end
        end
        @(posedge clk_aux);
        #1;
        spm_vld = 1'b0;
        lpm_vld = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk_aux);
        while (!busy) begin
            @(negedge clk_aux);
        end
        while (busy) begin
            @(negedge clk_aux);
        end
        repeat (4) @(negedge clk_aux);
    endtask

    task automatic check_results(test_t t);
        int exp_msgs;
        int exp_tmo;
        int j;
        exp_msgs = t.expect_fail ? 1 + `AUX_MAX_RETRIES : t.silents + t.defers + 1;
        exp_tmo  = (t.silents < exp_msgs) ? t.silents : exp_msgs;
        check_count("messages", exp_msgs, msg_count);
        check_count("timeouts", exp_tmo, tmo_count);
        check_count("acknowledges", exp_msgs - exp_tmo, ack_count);
        check_count("native failures", t.expect_fail ? 1 : 0, fail_count);
        check_src("reply_src", t.src_mask[0] ? SRC_SPM : SRC_LPM, reply_src);
        if (!t.expect_fail) begin
            check_reply("final reply", t.nack ? REPLY_NACK : REPLY_ACK, last_ack);
        end
        check_count("reply data bytes", sent_data.size(), rcv_data.size());
        for (j = 0; j < sent_data.size() && j < rcv_data.size(); j++) begin
            check_byte($sformatf("reply byte %0d", j), sent_data[j], rcv_data[j]);
        end
    endtask

    ////////////////////////////////////////
    // monitor and sink model
    ////////////////////////////////////////

    task automatic check_message();
        int j;
        check_count($sformatf("message %0d length", msg_count), exp_msg.size(),
                    cur_msg.size());
        for (j = 0; j < exp_msg.size() && j < cur_msg.size(); j++) begin
            check_byte($sformatf("message %0d byte %0d", msg_count, j), exp_msg[j],
                       cur_msg[j]);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk_aux) begin
        if (rst_n) begin
            if (aux_start_stop) begin
                cur_msg.push_back(aux_tx_data);
            end else if (cur_msg.size() > 0) begin
                check_message();
                cur_msg.delete();
                msg_count++;
            end
            if (reply_ack_vld) begin
                ack_count++;
                last_ack = reply_ack;
            end
            if (reply_data_vld) begin
                rcv_data.push_back(reply_data);
            end
            if (timer_timeout) begin
                tmo_count++;
            end
            if (native_failed) begin
                fail_count++;
            end
        end
    end

    // reply code sits in bits 5:4, ack 00 nack 01 defer 10
    task automatic answer_message(int idx);
        aux_byte_t code;
        aux_byte_t rnd;
        int        nbytes;
        int        i;
        if (idx >= sink_silents) begin
            repeat (3) @(posedge clk_aux);
            #1;
            if (idx < sink_silents + sink_defers) begin
                code = 8'h20;
            end else if (sink_nack) begin
                code = 8'h10;
            end else begin
                code = 8'h00;
            end
            nbytes = (code == 8'h00 && sink_read) ? int'(sink_len) + 1 : 0;
            phy_start_stop = 1'b1;
            aux_rx_data    = code;
            for (i = 0; i < nbytes; i++) begin
                @(posedge clk_aux);
                #1;
                rnd = aux_byte_t'($urandom);
                aux_rx_data = rnd;
                sent_data.push_back(rnd);
            end
            @(posedge clk_aux);
            #1;
            phy_start_stop = 1'b0;
            aux_rx_data    = '0;
        end
    endtask

    initial begin : sink_model
        forever begin
            @(posedge clk_aux);
            if (msg_count > answered) begin
                answered++;
                answer_message(answered - 1);
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk_aux);
            cycle_cnt++;
        end
        $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin : main_seq
        int    i;
        int    errs_before;
        int    passed;
        test_t t;
        void'($urandom(32'hcf779353));
        spm_vld        = 1'b0;
        spm_cmd        = NATIVE_WRITE;
        spm_address    = '0;
        spm_len        = '0;
        spm_data       = '0;
        lpm_vld        = 1'b0;
        lpm_cmd        = NATIVE_WRITE;
        lpm_address    = '0;
        lpm_len        = '0;
        lpm_data       = '0;
        aux_rx_data    = '0;
        phy_start_stop = 1'b0;
        err_count      = 0;
        msg_count      = 0;
        answered       = 0;
        passed         = 0;
        load_table();
        wait (rst_n == 1'b1);
        repeat (2) @(posedge clk_aux);
        for (i = 0; i < NUM_TESTS; i++) begin
            t           = test_tab[i];
            cur_name    = name_tab[i];
            errs_before = err_count;
            prepare_test(t);
            issue_request(t);
            wait_done();
            check_results(t);
            if (err_count == errs_before) begin
                passed++;
            end
            $display("test %0d %s: %s", i, cur_name,
                     (err_count == errs_before) ? "ok" : "failed");
        end
        if (DUT.u_asserts.viol_cnt != 0) begin
            err_count += DUT.u_asserts.viol_cnt;
            $display("%0d assertion violations during the run", DUT.u_asserts.viol_cnt);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS, passed,
                 NUM_TESTS - passed, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw
hw/aux_pkg.sv
hw/aux_req_if.sv
hw/aux_ctrl_unit.sv
hw/native_msg_encoder.sv
hw/aux_phy_link.sv
hw/reply_decoder.sv
hw/aux_native_top.sv
tests/aux_clk_gen.sv
tests/aux_asserts.sv
tests/aux_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module aux_tb -f all.f -o aux_sim \
    && ./obj_dir/aux_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^ALL CHECKS PASSED$" sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
